/* Bender.yml */
package:
  name: rv_core

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/rv_pipe_pkg.sv
  - rtl/rv_reg_file.sv
  - rtl/rv_fetch.sv
  - rtl/rv_decode.sv
  - rtl/rv_execute.sv
  - rtl/rv_retire.sv
  - rtl/rv_core_top.sv
  - target: test
    files:
      - bench/rv_core_tb.sv

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int          CLK_NS      = 8;
  localparam logic [31:0] RESET_PC    = 32'h0000_0100;
  localparam logic [31:0] NOP         = 32'h0000_0013;
  localparam int          IMEM_WORDS  = 1024;
  // program lengths of the six tests: 6 + 13 + 16 + 7 + 9 + 40
  localparam int          TOTAL_INSTR = 91;
  localparam int          NUM_TESTS   = 6;
  localparam int          WATCHDOG_CYCLES = TOTAL_INSTR + 20 * NUM_TESTS;

  localparam logic [2:0] F3_ADD  = 3'd0;
  localparam logic [2:0] F3_SLL  = 3'd1;
  localparam logic [2:0] F3_SLT  = 3'd2;
  localparam logic [2:0] F3_SLTU = 3'd3;
  localparam logic [2:0] F3_XOR  = 3'd4;
  localparam logic [2:0] F3_SR   = 3'd5;
  localparam logic [2:0] F3_OR   = 3'd6;
  localparam logic [2:0] F3_AND  = 3'd7;
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;

  logic        clk;
  logic        arst_n_i;
  logic [31:0] instr_i;
  logic [31:0] pc_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  int          prog_len;
  int          cycle_cnt = 0;
  int          c0;
  int          first_wb_cycle;
  logic        in_reset;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  integer      seed;

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) dut (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .instr_i    (instr_i),
    .pc_o       (pc_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ==========================================================================
  // instruction encoding and reference model
  // ==========================================================================

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(logic [6:0] opc, logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] alu_expect(logic [2:0] f3, logic alt, logic is_reg,
                                             logic [31:0] a, logic [31:0] b);
    case (f3)
      F3_ADD:  return (is_reg && alt) ? a - b : a + b;
      F3_SLL:  return a << b[4:0];
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  return a ^ b;
      F3_SR: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // walks the loaded program in order and queues every write to x1..x31
  task automatic run_model();
    logic [31:0] regs [0:31];
    logic [31:0] pc, ins, imm_i, val;
    logic [4:0]  rd;
    logic        writes;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    exp_rd_q.delete();
    exp_data_q.delete();
    pc = RESET_PC;
    steps = 0;
    while ((pc - RESET_PC) < 4 * prog_len && steps < 200) begin
      ins = imem[pc[11:2]];
      rd = ins[11:7];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      writes = 1'b1;
      val = '0;
      case (ins[6:0])
        7'b0110011: val = alu_expect(ins[14:12], ins[30], 1'b1, regs[ins[19:15]],
                                     regs[ins[24:20]]);
        7'b0010011: val = alu_expect(ins[14:12], ins[30], 1'b0, regs[ins[19:15]], imm_i);
        OPC_LUI:    val = {ins[31:12], 12'd0};
        OPC_AUIPC:  val = pc + {ins[31:12], 12'd0};
        7'b1101111: val = pc + 32'd4;
        default:    writes = 1'b0;
      endcase
      if (writes && rd != 5'd0) begin
        regs[rd] = val;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(val);
      end
      if (ins[6:0] == 7'b1101111) begin
        pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end else begin
        pc = pc + 32'd4;
      end
      steps++;
    end
  endtask

  // ==========================================================================
  // instruction memory and write-back monitor
  // ==========================================================================

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    if ($isunknown(addr) || addr >= IMEM_WORDS * 4) begin
      return NOP;
    end
    return imem[addr[11:2]];
  endfunction

  always @(negedge clk) begin
    instr_i = fetch_word(pc_o);
  end

  always @(negedge clk) begin : monitor
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    if (in_reset) begin
      if (wb_valid_o !== 1'b0) begin
        $display("Error at %0d ns: wb_valid_o = %b, expected 0", $time, wb_valid_o);
        err_cnt++;
      end
    end else if (arst_n_i && wb_valid_o === 1'b1) begin
      if (first_wb_cycle < 0) begin
        first_wb_cycle = cycle_cnt;
      end
      if (exp_rd_q.size() == 0) begin
        $display("unexpected write-back to x%0d at %0d ns, no write was outstanding",
                 wb_rd_o, $time);
        err_cnt++;
      end else begin
        exp_rd = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        if (wb_rd_o !== exp_rd) begin
          $display("Error at %0d ns: wb_rd_o = %0d, expected %0d", $time, wb_rd_o, exp_rd);
          err_cnt++;
        end
        if (wb_data_o !== exp_data) begin
          $display("Error at %0d ns: wb_data_o = %h, expected %h", $time, wb_data_o,
                   exp_data);
          err_cnt++;
        end
      end
    end
  end

  // ==========================================================================
  // test sequencing
  // ==========================================================================

  task automatic load_instr(logic [31:0] ins);
    imem[RESET_PC[11:2] + prog_len] = ins;
    prog_len++;
  endtask

  task automatic begin_test();
    @(negedge clk);
    arst_n_i = 1'b0;
    #1;
    in_reset = 1'b1;
    first_wb_cycle = -1;
    prog_len = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = NOP;
    end
  endtask

  task automatic release_reset();
    run_model();
    repeat (5) @(negedge clk);
    arst_n_i = 1'b1;
    in_reset = 1'b0;
    c0 = cycle_cnt;
  endtask

  // then a few idle cycles so that stray pulses still show up
  task automatic wait_drain(string name, int limit);
    int n;
    n = 0;
    while (exp_rd_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_rd_q.size() != 0) begin
      $display("%s: %0d expected write-backs never appeared", name, exp_rd_q.size());
      err_cnt++;
      exp_rd_q.delete();
      exp_data_q.delete();
    end
    repeat (6) @(negedge clk);
  endtask

  task automatic report_test(string name, int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("test %-12s ok", name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", name, err_cnt - err_start);
    end
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic reset_fetch_test();
    int err_start;
    err_start = err_cnt;
    begin_test();
    load_instr(i_type(12'd1, 5'd0, F3_ADD, 5'd1));
    load_instr(i_type(12'(-1), 5'd0, F3_ADD, 5'd2));
    load_instr(i_type(12'h7ff, 5'd0, F3_ADD, 5'd3));
    load_instr(i_type(12'h800, 5'd0, F3_ADD, 5'd4));
    load_instr(i_type(12'h100, 5'd0, F3_ADD, 5'd5));
    load_instr(i_type(12'h055, 5'd0, F3_ADD, 5'd6));
    release_reset();
    // sequential fetch from the reset address
    for (int i = 0; i < 8; i++) begin
      if (pc_o !== RESET_PC + 32'(4 * i)) begin
        $display("Error at %0d ns: pc_o = %h, expected %h", $time, pc_o,
                 RESET_PC + 32'(4 * i));
        err_cnt++;
      end
      @(negedge clk);
    end
    wait_drain("reset_fetch", prog_len + 12);
    report_test("reset_fetch", err_start);
  endtask

  task automatic imm_alu_test();
    int err_start;
    err_start = err_cnt;
    begin_test();
    load_instr(i_type(12'(-1234), 5'd0, F3_ADD, 5'd1));
    load_instr(i_type(12'h5a5, 5'd0, F3_ADD, 5'd2));
    load_instr(NOP);
    load_instr(NOP);
    load_instr(NOP);
    load_instr(i_type(12'd7, 5'd1, F3_SLT, 5'd3));
    load_instr(i_type(12'd7, 5'd1, F3_SLTU, 5'd4));
    load_instr(i_type(12'(-1), 5'd2, F3_XOR, 5'd5));
    load_instr(i_type(12'h0f0, 5'd2, F3_OR, 5'd6));
    load_instr(i_type(12'h03c, 5'd1, F3_AND, 5'd7));
    load_instr(i_type({F7_BASE, 5'd9}, 5'd2, F3_SLL, 5'd8));
    load_instr(i_type({F7_BASE, 5'd5}, 5'd1, F3_SR, 5'd9));
    load_instr(i_type({F7_ALT, 5'd5}, 5'd1, F3_SR, 5'd10));
    release_reset();
    wait_drain("imm_alu", prog_len + 12);
    // fetch to write-back latency of the first instruction
    if (first_wb_cycle >= 0 && first_wb_cycle - c0 != 4) begin
      $display("Error at %0d ns: wb_valid_o latency = %0d cycles, expected 4", $time,
               first_wb_cycle - c0);
      err_cnt++;
    end
    report_test("imm_alu", err_start);
  endtask

  // distance one reads the memory stage, two write-back, three the decode bypass
  task automatic forwarding_test();
    int err_start;
    err_start = err_cnt;
    begin_test();
    load_instr(i_type(12'h123, 5'd0, F3_ADD, 5'd1));
    load_instr(i_type(12'(-77), 5'd0, F3_ADD, 5'd2));
    load_instr(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3));
    load_instr(r_type(F7_ALT, 5'd1, 5'd3, F3_ADD, 5'd4));
    load_instr(r_type(F7_BASE, 5'd2, 5'd4, F3_SLL, 5'd5));
    load_instr(NOP);
    load_instr(r_type(F7_BASE, 5'd4, 5'd5, F3_SLT, 5'd6));
    load_instr(NOP);
    load_instr(r_type(F7_BASE, 5'd6, 5'd2, F3_SLTU, 5'd7));
    load_instr(NOP);
    load_instr(NOP);
    load_instr(r_type(F7_BASE, 5'd5, 5'd7, F3_XOR, 5'd8));
    load_instr(r_type(F7_BASE, 5'd1, 5'd8, F3_SR, 5'd9));
    load_instr(r_type(F7_ALT, 5'd9, 5'd2, F3_SR, 5'd10));
    load_instr(r_type(F7_BASE, 5'd9, 5'd10, F3_OR, 5'd11));
    load_instr(r_type(F7_BASE, 5'd10, 5'd11, F3_AND, 5'd12));
    release_reset();
    wait_drain("forwarding", prog_len + 12);
    report_test("forwarding", err_start);
  endtask

  task automatic upper_imm_test();
    int err_start;
    err_start = err_cnt;
    begin_test();
    load_instr(u_type(OPC_LUI, 20'habcde, 5'd1));
    load_instr(u_type(OPC_AUIPC, 20'h12345, 5'd2));
    load_instr(u_type(OPC_LUI, 20'hfffff, 5'd0));
    load_instr(r_type(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd3));
    load_instr(u_type(OPC_AUIPC, 20'h00001, 5'd0));
    load_instr(r_type(F7_BASE, 5'd0, 5'd1, F3_OR, 5'd4));
    load_instr(u_type(OPC_AUIPC, 20'h80000, 5'd5));
    release_reset();
    wait_drain("upper_imm", prog_len + 12);
    report_test("upper_imm", err_start);
  endtask

  task automatic jal_test();
    int err_start;
    err_start = err_cnt;
    begin_test();
    load_instr(i_type(12'd11, 5'd0, F3_ADD, 5'd1));
    load_instr(j_type(21'd16, 5'd5));
    load_instr(i_type(12'd1, 5'd0, F3_ADD, 5'd2));
    load_instr(i_type(12'd2, 5'd0, F3_ADD, 5'd3));
    load_instr(i_type(12'd3, 5'd0, F3_ADD, 5'd4));
    load_instr(r_type(F7_BASE, 5'd1, 5'd5, F3_ADD, 5'd6));
    load_instr(j_type(21'd8, 5'd0));
    load_instr(i_type(12'd9, 5'd0, F3_ADD, 5'd7));
    load_instr(i_type(12'd4, 5'd5, F3_ADD, 5'd8));
    release_reset();
    // first jump executes two cycles after its fetch, target shows one later
    repeat (4) @(negedge clk);
    if (pc_o !== RESET_PC + 32'd20) begin
      $display("Error at %0d ns: pc_o = %h, expected %h", $time, pc_o, RESET_PC + 32'd20);
      err_cnt++;
    end
    wait_drain("jal", prog_len + 12);
    report_test("jal", err_start);
  endtask

  task automatic random_test();
    int          err_start;
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    logic [6:0]  f7;
    err_start = err_cnt;
    begin_test();
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      f3 = r[11:9];
      alt = r[12] && (f3 == F3_SR || (r[13] && f3 == F3_ADD));
      f7 = alt ? F7_ALT : F7_BASE;
      // x0..x7 only, for dense dependencies
      if (r[13]) begin
        load_instr(r_type(f7, {2'b00, r[8:6]}, {2'b00, r[5:3]}, f3, {2'b00, r[2:0]}));
      end else if (f3 == F3_SLL || f3 == F3_SR) begin
        load_instr(i_type({f7, r[18:14]}, {2'b00, r[5:3]}, f3, {2'b00, r[2:0]}));
      end else begin
        load_instr(i_type(r[31:20], {2'b00, r[5:3]}, f3, {2'b00, r[2:0]}));
      end
    end
    release_reset();
    wait_drain("random", prog_len + 12);
    report_test("random", err_start);
  endtask

  // ==========================================================================
  // main sequence and watchdog
  // ==========================================================================

  initial begin
    arst_n_i = 1'b0;
    instr_i = NOP;
    in_reset = 1'b0;
    first_wb_cycle = -1;
    prog_len = 0;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    seed = 95073;
    reset_fetch_test();
    imm_alu_test();
    forwarding_test();
    upper_imm_test();
    jal_test();
    random_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_reg_file.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_retire.sv
rtl/rv_core_top.sv
bench/rv_core_tb.sv

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  wire logic               clk,
  input  wire logic               arst_n_i,
  input  wire rv_isa_pkg::instr_t instr_i,
  output rv_isa_pkg::word_t       pc_o,
  output logic                    wb_valid_o,
  output rv_isa_pkg::reg_addr_t   wb_rd_o,
  output rv_isa_pkg::word_t       wb_data_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // fetch to decode
  logic   id_valid;
  word_t  id_pc;
  instr_t id_instr;

  // decode to execute
  logic      ex_valid, ex_we, ex_op1_pc, ex_op2_imm, ex_jal;
  word_t     ex_pc, ex_op1, ex_op2, ex_imm;
  reg_addr_t ex_rs1, ex_rs2, ex_rd;
  alu_op_e   ex_alu_op;
  res_sel_e  ex_res_sel;

  // execute to retire
  logic      redirect, xr_valid, xr_we;
  word_t     target, xr_alu, xr_link, xr_imm;
  reg_addr_t xr_rd;
  res_sel_e  xr_res_sel;

  // forwarding paths
  logic      mem_valid, mem_we, wb_valid;
  reg_addr_t mem_rd, wb_rd;
  word_t     mem_result, wb_data;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .instr_i    (instr_i),
    .redirect_i (redirect),
    .target_i   (target),
    .pc_o       (pc_o),
    .id_valid_o (id_valid),
    .id_pc_o    (id_pc),
    .id_instr_o (id_instr)
  );

  rv_decode u_decode (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (id_valid),
    .pc_i         (id_pc),
    .instr_i      (id_instr),
    .flush_i      (redirect),
    .wb_we_i      (wb_valid),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .ex_valid_o   (ex_valid),
    .ex_pc_o      (ex_pc),
    .ex_rs1_o     (ex_rs1),
    .ex_rs2_o     (ex_rs2),
    .ex_rd_o      (ex_rd),
    .ex_we_o      (ex_we),
    .ex_op1_o     (ex_op1),
    .ex_op2_o     (ex_op2),
    .ex_imm_o     (ex_imm),
    .ex_alu_op_o  (ex_alu_op),
    .ex_op1_pc_o  (ex_op1_pc),
    .ex_op2_imm_o (ex_op2_imm),
    .ex_res_sel_o (ex_res_sel),
    .ex_jal_o     (ex_jal)
  );

  rv_execute u_execute (
    .valid_i      (ex_valid),
    .pc_i         (ex_pc),
    .rs1_i        (ex_rs1),
    .rs2_i        (ex_rs2),
    .rd_i         (ex_rd),
    .we_i         (ex_we),
    .op1_i        (ex_op1),
    .op2_i        (ex_op2),
    .imm_i        (ex_imm),
    .alu_op_i     (ex_alu_op),
    .op1_pc_i     (ex_op1_pc),
    .op2_imm_i    (ex_op2_imm),
    .res_sel_i    (ex_res_sel),
    .jal_i        (ex_jal),
    .mem_valid_i  (mem_valid),
    .mem_we_i     (mem_we),
    .mem_rd_i     (mem_rd),
    .mem_result_i (mem_result),
    .wb_valid_i   (wb_valid),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .redirect_o   (redirect),
    .target_o     (target),
    .mem_valid_o  (xr_valid),
    .mem_rd_o     (xr_rd),
    .mem_we_o     (xr_we),
    .alu_res_o    (xr_alu),
    .link_o       (xr_link),
    .imm_o        (xr_imm),
    .res_sel_o    (xr_res_sel)
  );

  rv_retire u_retire (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .valid_i      (xr_valid),
    .rd_i         (xr_rd),
    .we_i         (xr_we),
    .alu_res_i    (xr_alu),
    .link_i       (xr_link),
    .imm_i        (xr_imm),
    .res_sel_i    (xr_res_sel),
    .mem_valid_o  (mem_valid),
    .mem_we_o     (mem_we),
    .mem_rd_o     (mem_rd),
    .mem_result_o (mem_result),
    .wb_valid_o   (wb_valid),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // retire port
  assign wb_valid_o = wb_valid;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  input  wire logic                  valid_i,
  input  wire rv_isa_pkg::word_t     pc_i,
  input  wire rv_isa_pkg::instr_t    instr_i,
  input  wire logic                  flush_i,
  input  wire logic                  wb_we_i,
  input  wire rv_isa_pkg::reg_addr_t wb_rd_i,
  input  wire rv_isa_pkg::word_t     wb_data_i,
  output logic                       ex_valid_o,
  output rv_isa_pkg::word_t          ex_pc_o,
  output rv_isa_pkg::reg_addr_t      ex_rs1_o,
  output rv_isa_pkg::reg_addr_t      ex_rs2_o,
  output rv_isa_pkg::reg_addr_t      ex_rd_o,
  output logic                       ex_we_o,
  output rv_isa_pkg::word_t          ex_op1_o,
  output rv_isa_pkg::word_t          ex_op2_o,
  output rv_isa_pkg::word_t          ex_imm_o,
  output rv_isa_pkg::alu_op_e        ex_alu_op_o,
  output logic                       ex_op1_pc_o,
  output logic                       ex_op2_imm_o,
  output rv_pipe_pkg::res_sel_e      ex_res_sel_o,
  output logic                       ex_jal_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_e   opcode;
  reg_addr_t rs1, rs2, rd;
  logic [2:0] funct3;
  word_t     imm_i_type, imm_u_type, imm_j_type, imm;
  word_t     rdata1, rdata2, op1, op2;
  alu_op_e   alu_op;
  res_sel_e  res_sel;
  logic      known, we, op1_pc, op2_imm, jal;

  function automatic alu_op_e alu_decode(logic [2:0] f3, logic b30, logic is_reg);
    case (f3)
      F3_ADD:  return (is_reg && b30) ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      // bit 30 also picks SRAI in the immediate form
      F3_SRL:  return b30 ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ==========================================================================
  // fields and immediates
  // ==========================================================================

  assign opcode = opcode_e'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'd0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    known   = 1'b1;
    alu_op  = ALU_ADD;
    op1_pc  = 1'b0;
    op2_imm = 1'b0;
    res_sel = RES_ALU;
    jal     = 1'b0;
    imm     = imm_i_type;
    case (opcode)
      OPC_OP: alu_op = alu_decode(funct3, instr_i[30], 1'b1);
      OPC_OP_IMM: begin
        alu_op  = alu_decode(funct3, instr_i[30], 1'b0);
        op2_imm = 1'b1;
      end
      OPC_LUI: begin
        imm     = imm_u_type;
        res_sel = RES_IMM;
      end
      OPC_AUIPC: begin
        imm     = imm_u_type;
        op1_pc  = 1'b1;
        op2_imm = 1'b1;
      end
      OPC_JAL: begin
        imm     = imm_j_type;
        jal     = 1'b1;
        res_sel = RES_LINK;
      end
      // anything else retires without a write
      default: known = 1'b0;
    endcase
  end

  assign we = known && (rd != '0);

  // ==========================================================================
  // register read with write-back bypass
  // ==========================================================================

  rv_reg_file u_reg_file (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .we_i     (wb_we_i),
    .waddr_i  (wb_rd_i),
    .wdata_i  (wb_data_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  // register file writes only at the closing edge of write-back
  assign op1 = (wb_we_i && (wb_rd_i == rs1) && (rs1 != '0)) ? wb_data_i : rdata1;
  assign op2 = (wb_we_i && (wb_rd_i == rs2) && (rs2 != '0)) ? wb_data_i : rdata2;

  // ==========================================================================
  // decode/execute register
  // ==========================================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o <= 1'b0;
      ex_we_o    <= 1'b0;
      ex_jal_o   <= 1'b0;
    end else begin
      ex_valid_o <= valid_i & ~flush_i;
      ex_we_o    <= we;
      ex_jal_o   <= jal;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc_o      <= pc_i;
    ex_rs1_o     <= rs1;
    ex_rs2_o     <= rs2;
    ex_rd_o      <= rd;
    ex_op1_o     <= op1;
    ex_op2_o     <= op2;
    ex_imm_o     <= imm;
    ex_alu_op_o  <= alu_op;
    ex_op1_pc_o  <= op1_pc;
    ex_op2_imm_o <= op2_imm;
    ex_res_sel_o <= res_sel;
  end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire logic                  valid_i,
  input  wire rv_isa_pkg::word_t     pc_i,
  input  wire rv_isa_pkg::reg_addr_t rs1_i,
  input  wire rv_isa_pkg::reg_addr_t rs2_i,
  input  wire rv_isa_pkg::reg_addr_t rd_i,
  input  wire logic                  we_i,
  input  wire rv_isa_pkg::word_t     op1_i,
  input  wire rv_isa_pkg::word_t     op2_i,
  input  wire rv_isa_pkg::word_t     imm_i,
  input  wire rv_isa_pkg::alu_op_e   alu_op_i,
  input  wire logic                  op1_pc_i,
  input  wire logic                  op2_imm_i,
  input  wire rv_pipe_pkg::res_sel_e res_sel_i,
  input  wire logic                  jal_i,
  input  wire logic                  mem_valid_i,
  input  wire logic                  mem_we_i,
  input  wire rv_isa_pkg::reg_addr_t mem_rd_i,
  input  wire rv_isa_pkg::word_t     mem_result_i,
  input  wire logic                  wb_valid_i,
  input  wire rv_isa_pkg::reg_addr_t wb_rd_i,
  input  wire rv_isa_pkg::word_t     wb_data_i,
  output logic                       redirect_o,
  output rv_isa_pkg::word_t          target_o,
  output logic                       mem_valid_o,
  output rv_isa_pkg::reg_addr_t      mem_rd_o,
  output logic                       mem_we_o,
  output rv_isa_pkg::word_t          alu_res_o,
  output rv_isa_pkg::word_t          link_o,
  output rv_isa_pkg::word_t          imm_o,
  output rv_pipe_pkg::res_sel_e      res_sel_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  fwd_sel_e   fwd1, fwd2;
  word_t      src1, src2;
  word_t      alu_a, alu_b;
  logic [4:0] shamt;

  // memory stage is younger, so it beats write-back
  function automatic fwd_sel_e fwd_pick(reg_addr_t rs);
    if (rs == '0) begin
      return FWD_REG;
    end
    if (mem_valid_i && mem_we_i && (mem_rd_i == rs)) begin
      return FWD_MEM;
    end
    if (wb_valid_i && (wb_rd_i == rs)) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val);
    case (sel)
      FWD_MEM: return mem_result_i;
      FWD_WB:  return wb_data_i;
      default: return reg_val;
    endcase
  endfunction

  // ==========================================================================
  // operands
  // ==========================================================================

  // stage signals read inside the helpers must wake this block too
  always_comb begin
    fwd1 = fwd_pick(rs1_i);
    fwd2 = fwd_pick(rs2_i);
    src1 = fwd_mux(fwd1, op1_i);
    src2 = fwd_mux(fwd2, op2_i);
  end

  assign alu_a = op1_pc_i ? pc_i : src1;
  assign alu_b = op2_imm_i ? imm_i : src2;
  assign shamt = alu_b[4:0];

  // ==========================================================================
  // ALU
  // ==========================================================================

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res_o = alu_a + alu_b;
      ALU_SUB:  alu_res_o = alu_a - alu_b;
      ALU_SLL:  alu_res_o = alu_a << shamt;
      ALU_SLT:  alu_res_o = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_res_o = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:  alu_res_o = alu_a ^ alu_b;
      ALU_SRL:  alu_res_o = alu_a >> shamt;
      ALU_SRA:  alu_res_o = word_t'($signed(alu_a) >>> shamt);
      ALU_OR:   alu_res_o = alu_a | alu_b;
      default:  alu_res_o = alu_a & alu_b;
    endcase
  end

  // ==========================================================================
  // jump and hand-off to retire
  // ==========================================================================

  assign redirect_o = valid_i & jal_i;
  assign target_o   = pc_i + imm_i;
  assign link_o     = pc_i + word_t'(4);

  assign mem_valid_o = valid_i;
  assign mem_rd_o    = rd_i;
  assign mem_we_o    = we_i;
  assign imm_o       = imm_i;
  assign res_sel_o   = res_sel_i;

endmodule

`default_nettype wire

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  wire logic               clk,
  input  wire logic               arst_n_i,
  input  wire rv_isa_pkg::instr_t instr_i,
  input  wire logic               redirect_i,
  input  wire rv_isa_pkg::word_t  target_i,
  output rv_isa_pkg::word_t       pc_o,
  output logic                    id_valid_o,
  output rv_isa_pkg::word_t       id_pc_o,
  output rv_isa_pkg::instr_t      id_instr_o
);
  import rv_isa_pkg::*;

  word_t pc_q;
  word_t next_pc;

  // a jump from execute wins over sequential fetch
  assign next_pc = redirect_i ? target_i : pc_q + word_t'(4);
  assign pc_o    = pc_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q       <= RESET_PC;
      id_valid_o <= 1'b0;
    end else begin
      pc_q       <= next_pc;
      // word fetched alongside a redirect is on the wrong path
      id_valid_o <= ~redirect_i;
    end
  end

  // fetch/decode payload
  always_ff @(posedge clk) begin
    id_pc_o    <= pc_q;
    id_instr_o <= redirect_i ? NOP_INSTR : instr_i;
  end

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // data path width
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes the core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct3 of the integer ALU group
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // addi x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

/* rtl/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  // source of an execute operand
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

  // value written back to rd
  typedef enum logic [1:0] {
    RES_ALU  = 2'd0,
    RES_LINK = 2'd1,
    RES_IMM  = 2'd2
  } res_sel_e;

endpackage

`default_nettype wire

/* rtl/rv_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file (
  input  wire logic        clk,
  input  wire logic        arst_n_i,
  input  wire logic        we_i,
  input  wire logic [4:0]  waddr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [4:0]  raddr1_i,
  input  wire logic [4:0]  raddr2_i,
  output logic [31:0]      rdata1_o,
  output logic [31:0]      rdata2_o
);

  // x1..x31, x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // asynchronous read ports
  assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* rtl/rv_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_retire (
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  input  wire logic                  valid_i,
  input  wire rv_isa_pkg::reg_addr_t rd_i,
  input  wire logic                  we_i,
  input  wire rv_isa_pkg::word_t     alu_res_i,
  input  wire rv_isa_pkg::word_t     link_i,
  input  wire rv_isa_pkg::word_t     imm_i,
  input  wire rv_pipe_pkg::res_sel_e res_sel_i,
  output logic                       mem_valid_o,
  output logic                       mem_we_o,
  output rv_isa_pkg::reg_addr_t      mem_rd_o,
  output rv_isa_pkg::word_t          mem_result_o,
  output logic                       wb_valid_o,
  output rv_isa_pkg::reg_addr_t      wb_rd_o,
  output rv_isa_pkg::word_t          wb_data_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t    mem_alu, mem_link, mem_imm;
  res_sel_e mem_res_sel;

  // ==========================================================================
  // execute/memory register
  // ==========================================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_valid_o <= 1'b0;
      mem_we_o    <= 1'b0;
    end else begin
      mem_valid_o <= valid_i;
      mem_we_o    <= we_i;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd_o    <= rd_i;
    mem_alu     <= alu_res_i;
    mem_link    <= link_i;
    mem_imm     <= imm_i;
    mem_res_sel <= res_sel_i;
  end

  // result select, also the forwarding value for execute
  always_comb begin
    case (mem_res_sel)
      RES_LINK: mem_result_o = mem_link;
      RES_IMM:  mem_result_o = mem_imm;
      default:  mem_result_o = mem_alu;
    endcase
  end

  // ==========================================================================
  // memory/write-back register
  // ==========================================================================

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      // one pulse per retiring register write
      wb_valid_o <= mem_valid_o & mem_we_o;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= mem_rd_o;
    wb_data_o <= mem_result_o;
  end

endmodule

`default_nettype wire
